// File: flist.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/mem_pkg.sv
rtl/pc_unit.sv
rtl/controller_multicycle.sv
rtl/datapath_multicycle.sv
rtl/mem.sv
rtl/riscv.sv
testbench/riscv_chk.sv
testbench/tb_riscv.sv

// File: rtl/controller_multicycle.sv
`include "riscv_config.svh"

module controller_multicycle (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 tm,         // test mode parks the core in FETCH.
    input  logic [`RV_XLEN-1:0]  instr,
    input  logic                 zero_flag,  // ALU result is zero, so rs1 equals rs2.
    output rv_isa_pkg::ctrl_t    ctrl,
    output logic                 mem_we,
    output logic                 pc_step,
    output logic                 pc_load,
    output rv_isa_pkg::state_e   state
);
    rv_isa_pkg::state_e  state_d;
    rv_isa_pkg::opcode_e opcode;
    rv_isa_pkg::alu_op_e r_op;       // ALU operation selected by funct3 and funct7.

    assign opcode = rv_isa_pkg::opcode_e'(instr[6:0]);

    // only the funct codes of add, sub, and, or are decoded.
    always_comb begin
        case (instr[14:12])
            3'b110:  r_op = rv_isa_pkg::ALU_OR;
            3'b111:  r_op = rv_isa_pkg::ALU_AND;
            default: r_op = instr[30] ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) state <= rv_isa_pkg::FETCH;
        else         state <= state_d;
    end

    always_comb begin
        state_d        = state;
        ctrl.reg_we    = 1'b0;
        ctrl.ir_en     = 1'b0;
        ctrl.alu_src_a = rv_isa_pkg::SRC_A_REG;
        ctrl.alu_src_b = rv_isa_pkg::SRC_B_REG;
        ctrl.imm_src   = rv_isa_pkg::IMM_I;
        ctrl.alu_op    = rv_isa_pkg::ALU_ADD;
        ctrl.res_src   = rv_isa_pkg::RES_ALU;
        ctrl.addr_src  = rv_isa_pkg::ADDR_ALU;
        mem_we         = 1'b0;
        pc_step        = 1'b0;
        pc_load        = 1'b0;
        case (state)
            rv_isa_pkg::FETCH: begin
                ctrl.addr_src  = rv_isa_pkg::ADDR_PC;     // memory reads the word at pc.
                ctrl.alu_src_a = rv_isa_pkg::SRC_A_PC;    // the ALU sees pc plus four.
                ctrl.alu_src_b = rv_isa_pkg::SRC_B_FOUR;
                state_d        = rv_isa_pkg::DECODE;
            end
            rv_isa_pkg::DECODE: begin
                ctrl.ir_en = 1'b1;   // fetched word arrives now and is held from here on.
                pc_step    = 1'b1;
                case (opcode)
                    rv_isa_pkg::OPC_OP:     state_d = rv_isa_pkg::EXEC_R;
                    rv_isa_pkg::OPC_OP_IMM: state_d = rv_isa_pkg::EXEC_I;
                    rv_isa_pkg::OPC_LOAD,
                    rv_isa_pkg::OPC_STORE:  state_d = rv_isa_pkg::MEM_ADDR;
                    rv_isa_pkg::OPC_BRANCH: state_d = rv_isa_pkg::BRANCH;
                    default:                state_d = rv_isa_pkg::FETCH; // unknown is a nop.
                endcase
            end
            rv_isa_pkg::EXEC_R: begin
                ctrl.alu_op = r_op;
                state_d     = rv_isa_pkg::ALU_WB;
            end
            rv_isa_pkg::EXEC_I: begin
                ctrl.alu_src_b = rv_isa_pkg::SRC_B_IMM;  // addi is the only OP_IMM here.
                state_d        = rv_isa_pkg::ALU_WB;
            end
            rv_isa_pkg::MEM_ADDR: begin
                ctrl.alu_src_b = rv_isa_pkg::SRC_B_IMM;  // rs1 plus offset.
                if (opcode == rv_isa_pkg::OPC_STORE) begin
                    ctrl.imm_src = rv_isa_pkg::IMM_S;
                    state_d      = rv_isa_pkg::MEM_WRITE;
                end else begin
                    state_d = rv_isa_pkg::MEM_READ;
                end
            end
            rv_isa_pkg::MEM_READ: state_d = rv_isa_pkg::MEM_WB; // address from the result reg.
            rv_isa_pkg::MEM_WB: begin
                ctrl.reg_we  = 1'b1;
                ctrl.res_src = rv_isa_pkg::RES_MEM;
                state_d      = rv_isa_pkg::FETCH;
            end
            rv_isa_pkg::MEM_WRITE: begin
                mem_we  = 1'b1;     // rs2 goes out as write data.
                state_d = rv_isa_pkg::FETCH;
            end
            rv_isa_pkg::ALU_WB: begin
                ctrl.reg_we = 1'b1;
                state_d     = rv_isa_pkg::FETCH;
            end
            rv_isa_pkg::BRANCH: begin
                ctrl.alu_op  = rv_isa_pkg::ALU_SUB;  // equality test through the zero flag.
                ctrl.imm_src = rv_isa_pkg::IMM_B;
                pc_load      = zero_flag;
                state_d      = rv_isa_pkg::FETCH;
            end
            default: state_d = rv_isa_pkg::FETCH;
        endcase
        // test mode drops the instruction in flight and silences every strobe.
        if (tm) begin
            state_d     = rv_isa_pkg::FETCH;
            ctrl.reg_we = 1'b0;
            ctrl.ir_en  = 1'b0;
            mem_we      = 1'b0;
            pc_step     = 1'b0;
            pc_load     = 1'b0;
        end
    end

endmodule

// File: rtl/datapath_multicycle.sv
`include "riscv_config.svh"

module datapath_multicycle (
    input  logic                clk,
    input  logic                arst_n,
    input  rv_isa_pkg::ctrl_t   ctrl,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] old_pc,
    input  logic [`RV_XLEN-1:0] mem_rdata,
    output logic [`RV_XLEN-1:0] instr,
    output logic                zero_flag,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] mem_wdata,
    output logic [`RV_XLEN-1:0] branch_target,
    output logic                reg_we_dbg   // write that really lands in the register file.
);
    localparam logic [`RV_XLEN-1:0] FOUR = 4;

    logic [`RV_XLEN-1:0] ir_q;
    logic [`RV_XLEN-1:0] regs [32];
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic [`RV_XLEN-1:0] res_q;     // ALU result, one cycle later.
    logic [`RV_XLEN-1:0] wb_data;

    // in DECODE the word is still on the memory bus, so pass it straight through.
    assign instr = ctrl.ir_en ? mem_rdata : ir_q;

    always_ff @(posedge clk) begin
        if (ctrl.ir_en) ir_q <= mem_rdata;
    end

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // sign-extended immediates of the three supported formats.
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        case (ctrl.imm_src)
            rv_isa_pkg::IMM_S: imm = imm_s;
            rv_isa_pkg::IMM_B: imm = imm_b;
            default:           imm = imm_i;
        endcase
    end

    assign reg_we_dbg = ctrl.reg_we && (rd != 5'd0);  // x0 is never written.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (reg_we_dbg) begin
            regs[rd] <= wb_data;
        end
    end

    assign rs1_val = regs[rs1];   // regs[0] stays zero from reset on.
    assign rs2_val = regs[rs2];

    assign alu_a = (ctrl.alu_src_a == rv_isa_pkg::SRC_A_PC) ? pc : rs1_val;

    always_comb begin
        case (ctrl.alu_src_b)
            rv_isa_pkg::SRC_B_IMM:  alu_b = imm;
            rv_isa_pkg::SRC_B_FOUR: alu_b = FOUR;
            default:                alu_b = rs2_val;
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            rv_isa_pkg::ALU_SUB: alu_y = alu_a - alu_b;
            rv_isa_pkg::ALU_AND: alu_y = alu_a & alu_b;
            rv_isa_pkg::ALU_OR:  alu_y = alu_a | alu_b;
            default:             alu_y = alu_a + alu_b;
        endcase
    end

    assign zero_flag = (alu_y == '0);

    always_ff @(posedge clk) begin
        res_q <= alu_y;   // load/store address and R/I results wait here a cycle.
    end

    assign wb_data  = (ctrl.res_src == rv_isa_pkg::RES_MEM) ? mem_rdata : res_q;
    assign mem_addr = (ctrl.addr_src == rv_isa_pkg::ADDR_PC) ? pc : res_q;
    assign mem_wdata = rs2_val;

    // offset is relative to the branch itself, which old_pc still holds.
    // the controller selects the B immediate in BRANCH, the only state that loads pc.
    assign branch_target = old_pc + imm;

endmodule

// File: rtl/mem.sv
`include "riscv_config.svh"

module mem (
    input  logic                clk,
    input  logic [`RV_XLEN-1:0] addr,   // byte address.
    input  logic [`RV_XLEN-1:0] wdata,
    input  logic                we,
    output logic [`RV_XLEN-1:0] rdata,  // word addressed on the previous edge.
    output mem_pkg::errno_e     err     // status of that same address.
);
    localparam int IDX_W = $clog2(`RV_MEM_WORDS);

    logic [`RV_XLEN-1:0] words [`RV_MEM_WORDS];
    logic [`RV_XLEN-1:0] addr_q;
    logic [IDX_W-1:0]    idx;

    // classifies a byte address as good, misaligned or out of range.
    function automatic mem_pkg::errno_e addr_check(input logic [`RV_XLEN-1:0] a);
        if (a[1:0] != 2'b00)              return mem_pkg::EALIGN;
        else if ((a >> 2) >= `RV_MEM_WORDS) return mem_pkg::ERANGE;
        else                               return mem_pkg::ENONE;
    endfunction

    assign idx = addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (we && addr_check(addr) == mem_pkg::ENONE) words[idx] <= wdata;  // bad ones dropped.
        rdata  <= words[idx];   // read every cycle and return the old word on a write.
        addr_q <= addr;
    end

    assign err = addr_check(addr_q);

endmodule

// File: rtl/mem_pkg.sv
`include "riscv_config.svh"

package mem_pkg;

    // memory access status, reported next to the read data.
    typedef enum logic [1:0] {
        ENONE,   // good word address.
        EALIGN,  // address is not a multiple of four.
        ERANGE   // word index is past the end of the array.
    } errno_e;

    // wishbone classic request from the test master.
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [`RV_XLEN-1:0] adr;
        logic [`RV_XLEN-1:0] dat;  // write data.
    } wb_req_t;

    // wishbone classic response back to the test master.
    typedef struct packed {
        logic                ack;
        logic [`RV_XLEN-1:0] dat;  // read data, valid with ack.
        errno_e              err;
    } wb_rsp_t;

endpackage

// File: rtl/pc_unit.sv
`include "riscv_config.svh"

module pc_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pc_step,  // move on to the next sequential word.
    input  logic                pc_load,  // take the branch target.
    input  logic [`RV_XLEN-1:0] target,
    output logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] old_pc    // address of the instruction in flight.
);
    localparam logic [`RV_XLEN-1:0] STEP = 4;

    // a taken branch wins over a step, though the controller never raises both.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= `RV_RESET_PC;
            old_pc <= `RV_RESET_PC;
        end else if (pc_load) begin
            pc <= target;             // old_pc keeps the branch's own address.
        end else if (pc_step) begin
            pc     <= pc + STEP;
            old_pc <= pc;             // remember where this instruction came from.
        end
    end

endmodule

// File: rtl/riscv.sv
`include "riscv_config.svh"

module riscv (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                tm,       // hands the memory to the wishbone port.
    input  mem_pkg::wb_req_t    wb_req,
    output mem_pkg::wb_rsp_t    wb_rsp,
    output logic [`RV_XLEN-1:0] pc,       // debug view of the core.
    output logic [`RV_XLEN-1:0] instr,
    output logic                reg_we,
    output logic                mem_we
);
    rv_isa_pkg::ctrl_t   ctrl;
    rv_isa_pkg::state_e  state;         // watched by the bound checker.
    logic                core_mem_we;
    logic                pc_step;
    logic                pc_load;
    logic                zero_flag;
    logic [`RV_XLEN-1:0] old_pc;
    logic [`RV_XLEN-1:0] branch_target;
    logic [`RV_XLEN-1:0] core_addr;
    logic [`RV_XLEN-1:0] core_wdata;
    logic [`RV_XLEN-1:0] core_rdata;
    logic [`RV_XLEN-1:0] d_addr;
    logic [`RV_XLEN-1:0] d_wd;
    logic                d_we;
    logic [`RV_XLEN-1:0] d_rd;
    mem_pkg::errno_e     d_err;
    logic                wb_sel;        // a live wishbone cycle in test mode.
    logic                ack_q;

    pc_unit u_pc (
        .clk(clk), .arst_n(arst_n), .pc_step(pc_step), .pc_load(pc_load),
        .target(branch_target), .pc(pc), .old_pc(old_pc)
    );

    controller_multicycle u_ctrl (
        .clk(clk), .arst_n(arst_n), .tm(tm), .instr(instr), .zero_flag(zero_flag),
        .ctrl(ctrl), .mem_we(core_mem_we), .pc_step(pc_step), .pc_load(pc_load),
        .state(state)
    );

    datapath_multicycle u_dp (
        .clk(clk), .arst_n(arst_n), .ctrl(ctrl), .pc(pc), .old_pc(old_pc),
        .mem_rdata(core_rdata), .instr(instr), .zero_flag(zero_flag),
        .mem_addr(core_addr), .mem_wdata(core_wdata), .branch_target(branch_target),
        .reg_we_dbg(reg_we)
    );

    assign wb_sel = tm && wb_req.cyc && wb_req.stb;

    // the write lands on the edge that raises ack, and only once per request.
    assign d_addr = tm ? wb_req.adr : core_addr;
    assign d_wd   = tm ? wb_req.dat : core_wdata;
    assign d_we   = tm ? (wb_sel && wb_req.we && !ack_q) : core_mem_we;

    assign core_rdata = tm ? '0 : d_rd;
    assign mem_we     = core_mem_we && !tm;

    mem u_mem (
        .clk(clk), .addr(d_addr), .wdata(d_wd), .we(d_we), .rdata(d_rd), .err(d_err)
    );

    // ack follows the first sampled request by one clock and drops after one cycle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) ack_q <= 1'b0;
        else         ack_q <= wb_sel && !ack_q;
    end

    assign wb_rsp = '{
        ack: ack_q,
        dat: tm ? d_rd : '0,
        err: tm ? d_err : mem_pkg::ENONE
    };

endmodule

// File: rtl/riscv_config.svh
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// width of every data word, register and address in the core.
`define RV_XLEN 32

// depth of the shared instruction and data memory, counted in 32-bit words.
`define RV_MEM_WORDS 64

// the first instruction is fetched from here after arst_n is released.
`define RV_RESET_PC 32'h0000_0000

`endif

// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    // one state per step of the multicycle sequence.
    typedef enum logic [3:0] {
        FETCH, DECODE, EXEC_R, EXEC_I, MEM_ADDR,
        MEM_READ, MEM_WB, MEM_WRITE, ALU_WB, BRANCH
    } state_e;

    // major opcodes, bits 6:0 of the instruction.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // add, sub, and, or.
        OPC_OP_IMM = 7'b0010011,  // addi.
        OPC_LOAD   = 7'b0000011,  // lw.
        OPC_STORE  = 7'b0100011,  // sw.
        OPC_BRANCH = 7'b1100011   // beq.
    } opcode_e;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} alu_op_e;

    typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B} imm_src_e;

    typedef enum logic {SRC_A_REG, SRC_A_PC} alu_src_a_e;

    typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_FOUR} alu_src_b_e;

    typedef enum logic {RES_ALU, RES_MEM} res_src_e;   // register file write source.

    typedef enum logic {ADDR_PC, ADDR_ALU} addr_src_e; // memory address source.

    // everything the controller steers inside the datapath.
    typedef struct packed {
        logic       reg_we;     // register file write.
        logic       ir_en;      // instruction register capture.
        alu_src_a_e alu_src_a;
        alu_src_b_e alu_src_b;
        imm_src_e   imm_src;
        alu_op_e    alu_op;
        res_src_e   res_src;
        addr_src_e  addr_src;
    } ctrl_t;

endpackage

// File: testbench/riscv_chk.sv
`include "riscv_config.svh"

module riscv_chk (
    input logic                clk,
    input logic                arst_n,
    input logic                tm,
    input mem_pkg::wb_req_t    wb_req,
    input mem_pkg::wb_rsp_t    wb_rsp,
    input logic [`RV_XLEN-1:0] pc,
    input logic                mem_we,
    input rv_isa_pkg::state_e  state
);
    timeunit 1ns;
    timeprecision 1ps;

    int err_cnt = 0;   // the testbench polls this through the bind instance.

    // the slave answers only a live request made in test mode.
    ack_needs_request: assert property (@(posedge clk) disable iff (!arst_n)
        wb_rsp.ack |-> tm && wb_req.cyc && wb_req.stb)
        else begin
            $error("ack seen without cyc, stb and tm high");
            err_cnt++;
        end

    ack_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        wb_rsp.ack |=> !wb_rsp.ack)   // one acknowledge per request.
        else begin
            $error("ack held for more than one cycle");
            err_cnt++;
        end

    // the core may never write the memory once it has been handed to the port.
    no_core_write: assert property (@(posedge clk) disable iff (!arst_n)
        tm |-> !mem_we)
        else begin
            $error("core memory write while tm is high");
            err_cnt++;
        end

    pc_frozen: assert property (@(posedge clk) disable iff (!arst_n)
        tm |=> $stable(pc))
        else begin
            $error("pc moved while tm is high");
            err_cnt++;
        end

    parked_in_fetch: assert property (@(posedge clk) disable iff (!arst_n)
        tm |=> state == rv_isa_pkg::FETCH)   // the FSM is held at the start of a fetch.
        else begin
            $error("controller left FETCH while tm is high");
            err_cnt++;
        end

endmodule

bind riscv riscv_chk chk (
    .clk(clk), .arst_n(arst_n), .tm(tm), .wb_req(wb_req), .wb_rsp(wb_rsp),
    .pc(pc), .mem_we(core_mem_we), .state(state)
);

// File: testbench/tb_riscv.sv
`include "riscv_config.svh"

module tb_riscv;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_PROG  = 3;
    localparam int MAX_CHK = 8;
    localparam int N_WB    = 6;
    localparam int WB_COST = 3;                    // cycles budgeted per bus access.
    localparam logic [31:0] DATA    = 32'h0000_00C0;  // result area of the programs.
    localparam logic [31:0] LOAD_AT = 32'h0000_00E0;  // preloaded word for lw.
    localparam logic [31:0] BASE    = 32'h0000_0040;  // guard word for the bad accesses.

    logic                clk = 1'b0;
    logic                arst_n;
    logic                tm;
    mem_pkg::wb_req_t    wb_req;
    mem_pkg::wb_rsp_t    wb_rsp;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] instr;
    logic                reg_we;
    logic                mem_we;

    logic [31:0] rng = 32'h24408d99;
    int          cycles = 0;
    int          cycle_limit = 0;
    bit          at_reset_pc = 1'b0;   // pc must sit at the reset value while set.

    // program table: memory image, run length and the words expected afterwards.
    string           t_name [N_PROG];
    logic [31:0]     t_img  [N_PROG][`RV_MEM_WORDS];
    int              t_len  [N_PROG];
    int              t_exec [N_PROG];
    int              t_nchk [N_PROG];
    logic [31:0]     t_addr [N_PROG][MAX_CHK];
    logic [31:0]     t_exp  [N_PROG][MAX_CHK];
    logic [31:0]     wb_adr [N_WB];   // bus read-back table.
    logic [31:0]     wb_dat [N_WB];
    logic [31:0]     bad_adr [2];     // bad addresses and the status they must report.
    mem_pkg::errno_e bad_err [2];

    riscv uut (
        .clk(clk), .arst_n(arst_n), .tm(tm), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .pc(pc), .instr(instr), .reg_we(reg_we), .mem_we(mem_we)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // instruction encoders for the supported formats.
    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic sub,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input rv_isa_pkg::opcode_e opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_isa_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], rv_isa_pkg::OPC_BRANCH};
    endfunction

    task automatic emit(input int t, input logic [31:0] w);
        t_img[t][t_len[t]] = w;
        t_len[t] = t_len[t] + 1;
    endtask

    task automatic expect_at(input int t, input logic [31:0] a, input logic [31:0] v);
        t_addr[t][t_nchk[t]] = a;
        t_exp[t][t_nchk[t]]  = v;
        t_nchk[t] = t_nchk[t] + 1;
    endtask

    task automatic build_tables();
        logic [11:0] ia, ib, ik;
        logic [31:0] x [4];   // model of x0 to x3 for the branch program.
        logic [31:0] res [7];
        logic [4:0]  src [7];
        logic [31:0] r;
        bit          taken1, taken2;
        for (int t = 0; t < N_PROG; t++) begin
            t_len[t]  = 0;
            t_nchk[t] = 0;
            for (int i = 0; i < `RV_MEM_WORDS; i++) t_img[t][i] = '0;
        end
        for (int i = 0; i < N_WB; i++) begin
            wb_adr[i] = (next_rand() % `RV_MEM_WORDS) * 4;   // any good word.
            wb_dat[i] = next_rand();
        end
        bad_adr[0] = BASE + 2;                   // same word, not aligned.
        bad_err[0] = mem_pkg::EALIGN;
        bad_adr[1] = BASE + 4 * `RV_MEM_WORDS;   // one whole array past the guard word.
        bad_err[1] = mem_pkg::ERANGE;
        // alu program, each result stored, the last store shows x0.
        t_name[0] = "alu";
        ia = 12'(next_rand());
        ib = 12'(next_rand());
        emit(0, enc_i(rv_isa_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd0, ia));
        emit(0, enc_i(rv_isa_pkg::OPC_OP_IMM, 3'b000, 5'd2, 5'd0, ib));
        emit(0, enc_r(3'b000, 1'b0, 5'd3, 5'd1, 5'd2));
        emit(0, enc_r(3'b000, 1'b1, 5'd4, 5'd1, 5'd2));
        emit(0, enc_r(3'b111, 1'b0, 5'd5, 5'd1, 5'd2));
        emit(0, enc_r(3'b110, 1'b0, 5'd6, 5'd1, 5'd2));
        emit(0, enc_i(rv_isa_pkg::OPC_OP_IMM, 3'b000, 5'd0, 5'd1, 12'd5));  // lost write.
        src = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd0};
        res = '{sext12(ia), sext12(ib), sext12(ia) + sext12(ib), sext12(ia) - sext12(ib),
                sext12(ia) & sext12(ib), sext12(ia) | sext12(ib), 32'd0};
        for (int k = 0; k < 7; k++) begin
            emit(0, enc_s(5'd0, src[k], 12'(DATA + 4 * k)));
            expect_at(0, DATA + 4 * k, res[k]);
        end
        emit(0, enc_b(5'd0, 5'd0, 13'd0));   // branch to itself parks the core.
        t_exec[0] = t_len[0];
        // branch program, one taken beq and one not taken.
        t_name[1] = "branch";
        ia   = 12'(next_rand());
        x[0] = '0;
        x[1] = sext12(ia);
        x[2] = sext12(ia);
        x[3] = sext12(ia ^ 12'h001);
        taken1 = (x[1] == x[2]);
        taken2 = (x[1] == x[3]);
        emit(1, enc_i(rv_isa_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd0, ia));
        emit(1, enc_i(rv_isa_pkg::OPC_OP_IMM, 3'b000, 5'd2, 5'd0, ia));
        emit(1, enc_i(rv_isa_pkg::OPC_OP_IMM, 3'b000, 5'd3, 5'd0, ia ^ 12'h001));
        emit(1, enc_b(5'd1, 5'd2, 13'd8));
        emit(1, enc_s(5'd0, 5'd1, 12'(DATA)));
        emit(1, enc_b(5'd1, 5'd3, 13'd8));
        emit(1, enc_s(5'd0, 5'd3, 12'(DATA + 4)));
        emit(1, enc_s(5'd0, 5'd2, 12'(DATA + 8)));
        emit(1, enc_b(5'd0, 5'd0, 13'd0));
        expect_at(1, DATA, taken1 ? 32'd0 : x[1]);       // a taken branch skips its store.
        expect_at(1, DATA + 4, taken2 ? 32'd0 : x[3]);
        expect_at(1, DATA + 8, x[2]);
        t_exec[1] = t_len[1] - int'(taken1) - int'(taken2);
        // load program, a preloaded word plus a register.
        t_name[2] = "load";
        r  = next_rand();
        ik = 12'(next_rand());
        t_img[2][LOAD_AT >> 2] = r;
        emit(2, enc_i(rv_isa_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd0, ik));
        emit(2, enc_i(rv_isa_pkg::OPC_LOAD, 3'b010, 5'd2, 5'd0, 12'(LOAD_AT)));
        emit(2, enc_r(3'b000, 1'b0, 5'd3, 5'd2, 5'd1));
        emit(2, enc_s(5'd0, 5'd3, 12'(DATA)));
        emit(2, enc_s(5'd0, 5'd2, 12'(DATA + 4)));
        emit(2, enc_b(5'd0, 5'd0, 13'd0));
        expect_at(2, DATA, r + sext12(ik));
        expect_at(2, DATA + 4, r);
        expect_at(2, LOAD_AT, r);
        t_exec[2] = t_len[2];
    endtask

    // one classic bus cycle, started and ended on a falling edge.
    task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdat, output mem_pkg::errno_e err);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(negedge clk);
        while (!wb_rsp.ack) @(negedge clk);
        rdat = wb_rsp.dat;
        err  = wb_rsp.err;
        @(negedge clk);   // the request stays up through the edge that drops ack.
        wb_req = '0;
    endtask

    task automatic run_program(input int t);
        logic [31:0]     rd;
        mem_pkg::errno_e err;
        tm     = 1'b1;
        arst_n = 1'b0;
        @(negedge clk);
        arst_n      = 1'b1;
        at_reset_pc = 1'b1;
        for (int i = 0; i < `RV_MEM_WORDS; i++) begin
            wb_access(1'b1, i * 4, t_img[t][i], rd, err);
            check_word({t_name[t], " load"}, 32'(mem_pkg::ENONE), 32'(err));
        end
        at_reset_pc = 1'b0;
        tm          = 1'b0;
        arst_n      = 1'b0;   // pc restarts at the first program word.
        @(negedge clk);
        arst_n = 1'b1;
        repeat (5 * t_exec[t] + 10) @(negedge clk);
        tm = 1'b1;
        for (int k = 0; k < t_nchk[t]; k++) begin
            wb_access(1'b0, t_addr[t][k], '0, rd, err);
            check_word($sformatf("%s @%h", t_name[t], t_addr[t][k]), t_exp[t][k], rd);
            check_word($sformatf("%s @%h err", t_name[t], t_addr[t][k]),
                       32'(mem_pkg::ENONE), 32'(err));
        end
        // the core is parked on the final branch, so the IR still holds that word.
        check_word($sformatf("%s instr", t_name[t]), t_img[t][t_len[t] - 1], instr);
    endtask

    // watchdog and the test-mode rules that hold on every edge.
    always @(posedge clk) begin
        cycles++;
        assert (cycles <= cycle_limit) else begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
        if (arst_n && tm) begin
            assert (!reg_we && !mem_we) else begin
                $display("core wrote a register or memory while tm was high");
                abort_run();
            end
        end
        if (at_reset_pc) begin
            assert (pc === `RV_RESET_PC) else begin
                $display("Fail pc_hold: expected %h, actual %h", `RV_RESET_PC, pc);
                abort_run();
            end
        end
        assert (uut.chk.err_cnt == 0) else begin
            $display("bound checker flagged a bus or test-mode rule");
            abort_run();
        end
    end

    initial begin
        logic [31:0]     rd;
        logic [31:0]     guard;
        mem_pkg::errno_e err;
        int              budget;
        arst_n = 1'b0;
        tm     = 1'b1;
        wb_req = '0;
        build_tables();
        budget = 3 + WB_COST * (2 * N_WB + 2 + 6);
        for (int t = 0; t < N_PROG; t++) begin
            budget += 3 + WB_COST * (`RV_MEM_WORDS + t_nchk[t]) + 5 * t_exec[t] + 10;
        end
        cycle_limit = budget + 200;
        repeat (3) @(negedge clk);
        arst_n      = 1'b1;
        at_reset_pc = 1'b1;   // the core stays parked from reset on.
        for (int i = 0; i < N_WB; i++) begin
            wb_access(1'b1, wb_adr[i], wb_dat[i], rd, err);
            check_word($sformatf("wb_rw[%0d] write err", i), 32'(mem_pkg::ENONE), 32'(err));
            wb_access(1'b0, wb_adr[i], '0, rd, err);
            check_word($sformatf("wb_rw[%0d]", i), wb_dat[i], rd);
            check_word($sformatf("wb_rw[%0d] err", i), 32'(mem_pkg::ENONE), 32'(err));
        end
        guard = next_rand();
        wb_access(1'b1, BASE, guard, rd, err);
        for (int j = 0; j < 2; j++) begin
            wb_access(1'b1, bad_adr[j], ~guard, rd, err);   // must be dropped.
            check_word($sformatf("wb_bad[%0d] write err", j), 32'(bad_err[j]), 32'(err));
            wb_access(1'b0, bad_adr[j], '0, rd, err);
            check_word($sformatf("wb_bad[%0d] read err", j), 32'(bad_err[j]), 32'(err));
            wb_access(1'b0, BASE, '0, rd, err);
            check_word($sformatf("wb_bad[%0d] guard", j), guard, rd);
        end
        for (int t = 0; t < N_PROG; t++) run_program(t);
        if (uut.chk.err_cnt == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("bound checker reported %0d assertion failures", uut.chk.err_cnt);
            abort_run();
        end
    end

endmodule
